// ==== rtl/dma_cmd_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host command protocol of the to-PC DMA channel.
// Command codes, address and length descriptor fields, word counters
// and the abort stretch length.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package dma_cmd_pkg;

   // command code in bits [2:0] of every received word.
   typedef enum logic [2:0]
   {
      CMD_LENGTH     = 3'd1,  // transfer length in words.
      CMD_ADDR       = 3'd2,  // start address in words.
      CMD_IRQ_MATCH  = 3'd3,  // word count that raises interrupt 0.
      CMD_DESC_TABLE = 3'd4,  // descriptor table byte address.
      CMD_ABORT      = 3'd5
   } cmd_t;

   // start address in 8-byte words, bits [63:3] of a byte address.
   typedef logic [60:0] word_addr_t;

   // words still to send for the current descriptor.
   typedef logic [19:0] word_count_t;

   // running count of words sent since reset.
   typedef logic [28:0] words_sent_t;

   // cycles an abort holds the fetcher and length in reset.
   localparam int ABORT_STRETCH = 4;

endpackage

// ==== rtl/pcie_tx_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PCIe transmit side types.
// Data word, byte address, write burst length and status word.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package pcie_tx_pkg;

   typedef logic [63:0] word_t;

   typedef logic [63:0] byte_addr_t;

   // every posted write carries exactly this many beats.
   localparam int BURST_WORDS = 16;

   // words sent in [31:3], descriptor fetcher idle in bit 0.
   typedef logic [31:0] status_t;

endpackage

// ==== rtl/async_fwft_fifo.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dual-clock first-word-fall-through FIFO for 64-bit words.
// Gray-coded pointers cross domains through two flops each.
// Almost-empty flag means less than one burst is readable.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module async_fwft_fifo
  #(parameter int FIFO_DEPTH_LOG2 = 6)
  (
   input  logic               i_reset,
   input  logic               i_wr_clock,
   input  logic               i_wr_valid,
   input  pcie_tx_pkg::word_t i_wr_data,
   output logic               o_wr_ready,
   input  logic               i_rd_clock,
   input  logic               i_rd_read,
   output pcie_tx_pkg::word_t o_rd_data,
   output logic               o_rd_almost_empty
  );

   localparam int PTR_W = FIFO_DEPTH_LOG2 + 1;  // one wrap bit above the index.

   pcie_tx_pkg::word_t mem [1 << FIFO_DEPTH_LOG2];
   logic [PTR_W-1:0]   wr_bin;
   logic [PTR_W-1:0]   wr_gray;
   logic [PTR_W-1:0]   rd_gray_s1;
   logic [PTR_W-1:0]   rd_gray_s2;
   logic [PTR_W-1:0]   rd_bin;
   logic [PTR_W-1:0]   rd_gray;
   logic [PTR_W-1:0]   wr_gray_s1;
   logic [PTR_W-1:0]   wr_gray_s2;
   logic [PTR_W-1:0]   wr_bin_next;
   logic [PTR_W-1:0]   rd_bin_next;
   logic [PTR_W-1:0]   rd_count;
   logic               wr_full;

   function automatic logic [PTR_W-1:0] gray_to_bin(input logic [PTR_W-1:0] gray);
      logic [PTR_W-1:0] bin;
      bin[PTR_W-1] = gray[PTR_W-1];
      for (int i = PTR_W - 2; i >= 0; i--)
         bin[i] = bin[i+1] ^ gray[i];
      return bin;
   endfunction

   // full when the write pointer is one lap ahead of the read pointer.
   assign wr_full     = (wr_gray == {~rd_gray_s2[PTR_W-1 -: 2], rd_gray_s2[PTR_W-3:0]});
   assign o_wr_ready  = ~wr_full;
   assign wr_bin_next = wr_bin + 1'b1;

   always_ff @(posedge i_wr_clock)
   begin
      if (i_reset)
      begin
         wr_bin     <= '0;
         wr_gray    <= '0;
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
      end
      else
      begin
         rd_gray_s1 <= rd_gray;
         rd_gray_s2 <= rd_gray_s1;
         if (i_wr_valid && !wr_full)  // writes while full are dropped.
         begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
         end
      end
   end

   always_ff @(posedge i_wr_clock)
   begin
      if (i_wr_valid && !wr_full)
         mem[wr_bin[FIFO_DEPTH_LOG2-1:0]] <= i_wr_data;
   end

   // words visible to the read side.
   assign rd_count          = gray_to_bin(wr_gray_s2) - rd_bin;
   assign o_rd_almost_empty = (rd_count < PTR_W'(pcie_tx_pkg::BURST_WORDS));
   assign o_rd_data         = mem[rd_bin[FIFO_DEPTH_LOG2-1:0]];  // head word, no request.
   assign rd_bin_next       = rd_bin + 1'b1;

   always_ff @(posedge i_rd_clock)
   begin
      if (i_reset)
      begin
         rd_bin     <= '0;
         rd_gray    <= '0;
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
      end
      else
      begin
         wr_gray_s1 <= wr_gray;
         wr_gray_s2 <= wr_gray_s1;
         if (i_rd_read && (rd_count != '0))
         begin
            rd_bin  <= rd_bin_next;
            rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
         end
      end
   end

endmodule

// ==== rtl/descriptor_fetch.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Descriptor fetcher.
// Issues one read request per table address and queues the returned
// length and address descriptors for the channel.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module descriptor_fetch
  #(parameter int DESC_DEPTH_LOG2 = 2)
  (
   input  logic                    i_clock,
   input  logic                    i_reset,
   input  logic                    i_table_write,
   input  logic                    i_desc_write,
   input  pcie_tx_pkg::word_t      i_wdata,
   input  logic                    i_rc_last,
   input  logic                    i_rr_ready,
   input  logic                    i_desc_read,
   output logic                    o_rr_valid,
   output pcie_tx_pkg::byte_addr_t o_rr_addr,
   output logic                    o_desc_valid,
   output pcie_tx_pkg::word_t      o_desc_data,
   output logic                    o_desc_idle
  );

   localparam int PTR_W = DESC_DEPTH_LOG2 + 1;

   pcie_tx_pkg::word_t queue [1 << DESC_DEPTH_LOG2];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic               queue_empty;
   logic               queue_full;
   logic               outstanding;  // request issued, rc_last not yet seen.
   logic               table_take;

   // a new table address is taken only once the previous completion is back.
   assign table_take   = i_table_write && !outstanding;
   assign queue_empty  = (wr_ptr == rd_ptr);
   assign queue_full   = (wr_ptr == {~rd_ptr[PTR_W-1], rd_ptr[PTR_W-2:0]});
   assign o_desc_valid = !queue_empty;
   assign o_desc_data  = queue[rd_ptr[DESC_DEPTH_LOG2-1:0]];
   assign o_desc_idle  = !outstanding && queue_empty;

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         outstanding <= 1'b0;
         o_rr_valid  <= 1'b0;
         wr_ptr      <= '0;
         rd_ptr      <= '0;
      end
      else
      begin
         if (table_take)
         begin
            outstanding <= 1'b1;
            o_rr_valid  <= 1'b1;
         end
         else
         begin
            if (i_rc_last)
               outstanding <= 1'b0;
            if (o_rr_valid && i_rr_ready)
               o_rr_valid <= 1'b0;  // one request per handshake.
         end
         if (i_desc_write && !queue_full)
            wr_ptr <= wr_ptr + 1'b1;
         if (i_desc_read && !queue_empty)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge i_clock)
   begin
      if (table_take)
         o_rr_addr <= {i_wdata[63:3], 3'b000};  // command code bits masked off.
      if (i_desc_write && !queue_full)
         queue[wr_ptr[DESC_DEPTH_LOG2-1:0]] <= i_wdata;
   end

endmodule

// ==== rtl/tpc_dma_channel.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// To-PC DMA channel core.
// Command decode, descriptor loading, burst sequencer, word counters,
// abort stretch, status word and interrupt one-shots.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tpc_dma_channel
  (
   input  logic                    i_clock,
   input  logic                    i_reset,
   input  pcie_tx_pkg::word_t      i_rx_data,
   input  logic                    i_rx_data_valid,
   input  logic                    i_wr_ready,
   input  pcie_tx_pkg::word_t      i_fifo_data,
   input  logic                    i_fifo_almost_empty,
   input  logic                    i_desc_valid,
   input  pcie_tx_pkg::word_t      i_desc_data,
   input  logic                    i_desc_idle,
   output logic                    o_fifo_read,
   output logic                    o_wr_valid,
   output pcie_tx_pkg::byte_addr_t o_wr_addr,
   output logic                    o_wr_last,
   output pcie_tx_pkg::word_t      o_wr_data,
   output logic                    o_table_write,
   output logic                    o_desc_write,
   output logic                    o_desc_read,
   output logic                    o_fetch_reset,
   output pcie_tx_pkg::status_t    o_status,
   output logic [1:0]              o_interrupt
  );

   localparam int BEAT_W  = $clog2(pcie_tx_pkg::BURST_WORDS);
   localparam int ABORT_W = $clog2(dma_cmd_pkg::ABORT_STRETCH + 1);

   typedef enum logic {IDLE, BURST} state_t;

   state_t                   state;
   logic [BEAT_W-1:0]        beat;
   dma_cmd_pkg::cmd_t        rx_cmd;
   dma_cmd_pkg::cmd_t        desc_cmd;
   dma_cmd_pkg::word_addr_t  addr;
   dma_cmd_pkg::word_count_t length;
   dma_cmd_pkg::words_sent_t words_sent;
   dma_cmd_pkg::words_sent_t match_value;
   logic [ABORT_W-1:0]       abort_count;
   logic                     enabled;
   logic                     abort_cmd;
   logic                     abort_busy;
   logic                     accept;
   logic                     launch_ok;
   logic                     match_now;
   logic                     match_prev;
   logic                     idle_prev;

   assign rx_cmd   = dma_cmd_pkg::cmd_t'(i_rx_data[2:0]);
   assign desc_cmd = dma_cmd_pkg::cmd_t'(i_desc_data[2:0]);

   // length and address words, direct or from a completion, go to the queue.
   assign o_desc_write  = i_rx_data_valid &&
                          ((rx_cmd == dma_cmd_pkg::CMD_LENGTH) || (rx_cmd == dma_cmd_pkg::CMD_ADDR));
   assign o_table_write = i_rx_data_valid && (rx_cmd == dma_cmd_pkg::CMD_DESC_TABLE);
   assign abort_cmd     = i_rx_data_valid && (rx_cmd == dma_cmd_pkg::CMD_ABORT);
   assign abort_busy    = abort_cmd || (abort_count != '0);
   assign o_desc_read   = i_desc_valid && !enabled;  // descriptors load only between transfers.

   assign accept      = o_wr_valid && i_wr_ready;
   assign o_fifo_read = accept || (state == BURST);  // one pop per beat.
   assign launch_ok   = enabled && !i_fifo_almost_empty && (length != '0) && !abort_busy;
   assign o_wr_last   = (state == BURST) && (beat == BEAT_W'(pcie_tx_pkg::BURST_WORDS - 1));
   assign o_wr_addr   = {addr, 3'b000};
   assign o_wr_data   = i_fifo_data;

   assign match_now = (words_sent == match_value);
   assign o_status  = {words_sent, 2'b00, i_desc_idle};

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         state         <= IDLE;
         beat          <= '0;
         o_wr_valid    <= 1'b0;
         enabled       <= 1'b0;
         words_sent    <= '0;
         match_value   <= '1;  // nothing armed.
         abort_count   <= '0;
         o_fetch_reset <= 1'b1;
         match_prev    <= 1'b1;
         idle_prev     <= 1'b1;  // fetcher comes out of reset idle.
         o_interrupt   <= 2'b00;
      end
      else
      begin
         o_wr_valid <= (state == IDLE) && !accept && launch_ok;
         case (state)
            IDLE:
               if (accept)
               begin
                  state <= BURST;
                  beat  <= BEAT_W'(1);  // acceptance cycle is beat 0.
               end
            BURST:
            begin
               beat <= beat + 1'b1;
               if (o_wr_last)
                  state <= IDLE;
            end
         endcase

         if (o_desc_read && (desc_cmd == dma_cmd_pkg::CMD_ADDR))
            enabled <= 1'b1;
         else if (length == '0)
            enabled <= 1'b0;

         words_sent <= words_sent + dma_cmd_pkg::words_sent_t'(o_fifo_read);
         if (i_rx_data_valid && (rx_cmd == dma_cmd_pkg::CMD_IRQ_MATCH))
            match_value <= i_rx_data[31:3];

         if (abort_cmd)
            abort_count <= ABORT_W'(dma_cmd_pkg::ABORT_STRETCH);
         else if (abort_count != '0)
            abort_count <= abort_count - 1'b1;
         o_fetch_reset <= (abort_count != '0);

         // one-shots on the rising edge of each condition.
         match_prev     <= match_now;
         idle_prev      <= i_desc_idle;
         o_interrupt[0] <= match_now && !match_prev;
         o_interrupt[1] <= i_desc_idle && !idle_prev;
      end
   end

   always_ff @(posedge i_clock)
   begin
      if (i_reset || o_fetch_reset)
         length <= '0;
      else if (o_desc_read && (desc_cmd == dma_cmd_pkg::CMD_LENGTH))
         length <= i_desc_data[22:3];
      else if (o_fifo_read && (length != '0))  // a burst after abort runs on at zero.
         length <= length - 1'b1;
   end

   always_ff @(posedge i_clock)
   begin
      if (o_desc_read && (desc_cmd == dma_cmd_pkg::CMD_ADDR))
         addr <= i_desc_data[63:3];
      else if (o_fifo_read)
         addr <= addr + 1'b1;
   end

endmodule

// ==== rtl/tpc_dma_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the to-PC DMA channel.
// Joins the channel core, the data FIFO and the descriptor fetcher.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tpc_dma_top
  #(parameter int FIFO_DEPTH_LOG2 = 6,
    parameter int DESC_DEPTH_LOG2 = 2)
  (
   input  logic                    i_clock,
   input  logic                    i_reset,
   input  pcie_tx_pkg::word_t      i_rx_data,
   input  logic                    i_rx_data_valid,
   input  logic                    i_rc_last,
   input  logic                    i_rr_ready,
   input  logic                    i_wr_ready,
   input  logic                    i_fifo_clock,
   input  logic                    i_fifo_write,
   input  pcie_tx_pkg::word_t      i_fifo_data,
   output pcie_tx_pkg::status_t    o_status,
   output logic [1:0]              o_interrupt,
   output logic                    o_rr_valid,
   output pcie_tx_pkg::byte_addr_t o_rr_addr,
   output logic                    o_wr_valid,
   output pcie_tx_pkg::byte_addr_t o_wr_addr,
   output logic                    o_wr_last,
   output pcie_tx_pkg::word_t      o_wr_data,
   output logic                    o_fifo_ready
  );

   pcie_tx_pkg::word_t fifo_head;
   pcie_tx_pkg::word_t desc_data;
   logic               fifo_read;
   logic               fifo_almost_empty;
   logic               table_write;
   logic               desc_write;
   logic               desc_read;
   logic               desc_valid;
   logic               desc_idle;
   logic               fetch_reset;  // reset or stretched abort.

   tpc_dma_channel tpc_dma_channel_inst
     (
      .i_clock             (i_clock),
      .i_reset             (i_reset),
      .i_rx_data           (i_rx_data),
      .i_rx_data_valid     (i_rx_data_valid),
      .i_wr_ready          (i_wr_ready),
      .i_fifo_data         (fifo_head),
      .i_fifo_almost_empty (fifo_almost_empty),
      .i_desc_valid        (desc_valid),
      .i_desc_data         (desc_data),
      .i_desc_idle         (desc_idle),
      .o_fifo_read         (fifo_read),
      .o_wr_valid          (o_wr_valid),
      .o_wr_addr           (o_wr_addr),
      .o_wr_last           (o_wr_last),
      .o_wr_data           (o_wr_data),
      .o_table_write       (table_write),
      .o_desc_write        (desc_write),
      .o_desc_read         (desc_read),
      .o_fetch_reset       (fetch_reset),
      .o_status            (o_status),
      .o_interrupt         (o_interrupt)
     );

   async_fwft_fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) async_fwft_fifo_inst
     (
      .i_reset           (i_reset),
      .i_wr_clock        (i_fifo_clock),
      .i_wr_valid        (i_fifo_write),
      .i_wr_data         (i_fifo_data),
      .o_wr_ready        (o_fifo_ready),
      .i_rd_clock        (i_clock),
      .i_rd_read         (fifo_read),
      .o_rd_data         (fifo_head),
      .o_rd_almost_empty (fifo_almost_empty)
     );

   descriptor_fetch #(.DESC_DEPTH_LOG2(DESC_DEPTH_LOG2)) descriptor_fetch_inst
     (
      .i_clock       (i_clock),
      .i_reset       (fetch_reset),
      .i_table_write (table_write),
      .i_desc_write  (desc_write),
      .i_wdata       (i_rx_data),
      .i_rc_last     (i_rc_last),
      .i_rr_ready    (i_rr_ready),
      .i_desc_read   (desc_read),
      .o_rr_valid    (o_rr_valid),
      .o_rr_addr     (o_rr_addr),
      .o_desc_valid  (desc_valid),
      .o_desc_data   (desc_data),
      .o_desc_idle   (desc_idle)
     );

endmodule

// ==== testbench/tpc_dma_props.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions on write burst and read request timing,
// bound into the DMA top level.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tpc_dma_props
  (
   input logic                    i_clock,
   input logic                    i_reset,
   input logic                    o_wr_valid,
   input logic                    i_wr_ready,
   input logic                    o_wr_last,
   input logic                    o_rr_valid,
   input logic                    i_rr_ready,
   input pcie_tx_pkg::byte_addr_t o_rr_addr
  );

   // last beat comes 15 cycles after acceptance.
   assert property (@(posedge i_clock) disable iff (i_reset)
                    (o_wr_valid && i_wr_ready) |-> ##15 o_wr_last)
      else $error("wr_last not 15 cycles after burst acceptance");

   assert property (@(posedge i_clock) disable iff (i_reset)
                    (o_wr_valid && i_wr_ready) |=> !o_wr_valid [*15])
      else $error("wr_valid raised during a burst");

   // pending request keeps valid and address.
   assert property (@(posedge i_clock) disable iff (i_reset)
                    (o_rr_valid && !i_rr_ready) |=> (o_rr_valid && $stable(o_rr_addr)))
      else $error("read request dropped before acceptance");

endmodule

bind tpc_dma_top tpc_dma_props tpc_dma_props_inst
  (
   .i_clock    (i_clock),
   .i_reset    (i_reset),
   .o_wr_valid (o_wr_valid),
   .i_wr_ready (i_wr_ready),
   .o_wr_last  (o_wr_last),
   .o_rr_valid (o_rr_valid),
   .i_rr_ready (i_rr_ready),
   .o_rr_addr  (o_rr_addr)
  );

// ==== testbench/tb_tpc_dma.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the to-PC DMA channel.
// Clocks, host-memory model, stimulus table, burst scoreboard,
// interrupt monitor and closing status line.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_tpc_dma;

   localparam int LIMIT = 2000;  // cycles allowed for any single wait.
   localparam int NROWS = 4;

   typedef struct {
      int          push_words;
      int          desc_length;
      logic [60:0] start_word;
      int          match_value;
      logic [7:0]  ready_pattern;
      bit          abort;
   } row_t;

   logic                    i_clock;
   logic                    i_reset;
   pcie_tx_pkg::word_t      i_rx_data;
   logic                    i_rx_data_valid;
   logic                    i_rc_last;
   logic                    i_rr_ready;
   logic                    i_wr_ready;
   logic                    i_fifo_clock;
   logic                    i_fifo_write;
   pcie_tx_pkg::word_t      i_fifo_data;
   pcie_tx_pkg::status_t    o_status;
   logic [1:0]              o_interrupt;
   logic                    o_rr_valid;
   pcie_tx_pkg::byte_addr_t o_rr_addr;
   logic                    o_wr_valid;
   pcie_tx_pkg::byte_addr_t o_wr_addr;
   logic                    o_wr_last;
   pcie_tx_pkg::word_t      o_wr_data;
   logic                    o_fifo_ready;

   row_t                    rows [NROWS];
   pcie_tx_pkg::word_t      host_mem [64];
   pcie_tx_pkg::word_t      expect_q [$];
   logic [31:0]             lfsr_state;
   logic [7:0]              bp_pattern;
   logic [2:0]              bp_phase;
   pcie_tx_pkg::byte_addr_t expect_addr;
   int                      cur_match;
   int                      errors;
   int                      checks;
   int                      bursts;
   int                      words_seen;
   int                      words_lag;
   int                      irq0_count;
   int                      irq1_count;
   int                      rr_count;

   tpc_dma_top #(.FIFO_DEPTH_LOG2(6), .DESC_DEPTH_LOG2(2)) tpc_dma_top_inst
     (
      .i_clock         (i_clock),
      .i_reset         (i_reset),
      .i_rx_data       (i_rx_data),
      .i_rx_data_valid (i_rx_data_valid),
      .i_rc_last       (i_rc_last),
      .i_rr_ready      (i_rr_ready),
      .i_wr_ready      (i_wr_ready),
      .i_fifo_clock    (i_fifo_clock),
      .i_fifo_write    (i_fifo_write),
      .i_fifo_data     (i_fifo_data),
      .o_status        (o_status),
      .o_interrupt     (o_interrupt),
      .o_rr_valid      (o_rr_valid),
      .o_rr_addr       (o_rr_addr),
      .o_wr_valid      (o_wr_valid),
      .o_wr_addr       (o_wr_addr),
      .o_wr_last       (o_wr_last),
      .o_wr_data       (o_wr_data),
      .o_fifo_ready    (o_fifo_ready)
     );

   initial
   begin
      i_clock = 1'b0;
      forever #4 i_clock = ~i_clock;
   end

   initial
   begin
      i_fifo_clock = 1'b0;
      forever #5 i_fifo_clock = ~i_fifo_clock;
   end

   // write-side back-pressure with one pattern bit per cycle.
   initial
   begin
      bp_phase = '0;
      forever
      begin
         @(negedge i_clock);
         i_wr_ready = bp_pattern[bp_phase];
         bp_phase   = bp_phase + 1'b1;
      end
   end

   task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
                          input string what);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("ERROR %0t: %s got %h expected %h", $time, what, actual, expected);
      end
   endtask

   task automatic timeout_fail(input string what);
      $display("timeout while waiting for %s", what);
      $display("checks %0d errors %0d", checks, errors);
      $display("STATUS: FAIL");
      $finish;
   endtask

   // fibonacci lfsr with taps 32 22 2 1 and one step per data bit.
   function automatic pcie_tx_pkg::word_t next_data();
      pcie_tx_pkg::word_t w;
      logic               fb;
      for (int i = 0; i < 64; i++)
      begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         w[i]       = fb;
      end
      return w;
   endfunction

   task automatic send_rx(input pcie_tx_pkg::word_t w, input logic last);
      @(negedge i_clock);
      i_rx_data       = w;
      i_rx_data_valid = 1'b1;
      i_rc_last       = last;
      @(negedge i_clock);
      i_rx_data_valid = 1'b0;
      i_rc_last       = 1'b0;
   endtask

   task automatic push_words(input int count);
      pcie_tx_pkg::word_t w;
      int                 t;
      for (int n = 0; n < count; n++)
      begin
         @(negedge i_fifo_clock);
         t = 0;
         while (!o_fifo_ready)
         begin
            i_fifo_write = 1'b0;
            @(negedge i_fifo_clock);
            t++;
            if (t > LIMIT)
               timeout_fail("fifo ready");
         end
         w            = next_data();
         i_fifo_write = 1'b1;
         i_fifo_data  = w;
         expect_q.push_back(w);
      end
      @(negedge i_fifo_clock);
      i_fifo_write = 1'b0;
   endtask

   // host memory answers a read request with length then address descriptor.
   task automatic serve_read(input pcie_tx_pkg::byte_addr_t table_addr);
      int t;
      int idx;
      t = 0;
      while (!o_rr_valid)
      begin
         @(negedge i_clock);
         t++;
         if (t > LIMIT)
            timeout_fail("read request");
      end
      compare(o_rr_addr, table_addr, "read request address");
      idx = int'((table_addr >> 3) % 64);
      @(negedge i_clock);
      i_rr_ready = 1'b1;
      @(negedge i_clock);
      i_rr_ready = 1'b0;
      send_rx(host_mem[idx], 1'b0);
      send_rx(host_mem[(idx + 1) % 64], 1'b1);
   endtask

   // scoreboard for bursts, beats and interrupts.
   initial
   begin
      bit in_burst;
      bit prev_hold;
      int beat_idx;
      in_burst  = 0;
      prev_hold = 0;
      beat_idx  = 0;
      forever
      begin
         @(posedge i_clock);
         if (!i_reset)
         begin
            if (o_interrupt[0])
            begin
               irq0_count++;
               compare(words_lag, cur_match, "words sent at match interrupt");
            end
            if (o_interrupt[1])
               irq1_count++;
            if (o_rr_valid && i_rr_ready)
               rr_count++;
            words_lag = words_seen;
            if (prev_hold)
               compare(o_wr_valid, 1'b1, "valid held under back-pressure");
            prev_hold = o_wr_valid && !i_wr_ready;
            if (!in_burst && o_wr_valid && i_wr_ready)
            begin
               bursts++;
               compare(o_wr_addr, expect_addr, "burst address");
               expect_addr = expect_addr + 64'd128;
               in_burst    = 1;
               beat_idx    = 0;
            end
            if (in_burst)
            begin
               compare(expect_q.size() != 0, 1'b1, "expected data available");
               if (expect_q.size() != 0)
                  compare(o_wr_data, expect_q.pop_front(), "beat data");
               compare(o_wr_last, beat_idx == 15, "last flag");
               words_seen++;
               beat_idx++;
               if (beat_idx == 16)
                  in_burst = 0;
            end
         end
      end
   end

   initial
   begin
      int t;
      int base_bursts;
      int base_irq0;
      int base_irq1;
      int base_rr;
      int expect_words;
      int idx;
      pcie_tx_pkg::byte_addr_t table_addr;

      rows[0] = '{32, 32, 61'h200, 16, 8'hff, 1'b0};
      rows[1] = '{64, 64, 61'h4000, 80, 8'b1011_0110, 1'b0};
      rows[2] = '{16, 16, 61'h6008, 112, 8'b0011_1100, 1'b0};
      rows[3] = '{32, 64, 61'h8000, 128, 8'h00, 1'b1};  // abort row starts under back-pressure.

      lfsr_state      = 32'hae7b_9c41;
      errors          = 0;
      checks          = 0;
      bursts          = 0;
      words_seen      = 0;
      words_lag       = 0;
      irq0_count      = 0;
      irq1_count      = 0;
      rr_count        = 0;
      cur_match       = -1;
      expect_addr     = '0;
      expect_words    = 0;
      bp_pattern      = 8'hff;
      i_reset         = 1'b1;
      i_rx_data       = '0;
      i_rx_data_valid = 1'b0;
      i_rc_last       = 1'b0;
      i_rr_ready      = 1'b0;
      i_wr_ready      = 1'b0;
      i_fifo_write    = 1'b0;
      i_fifo_data     = '0;

      repeat (4) @(posedge i_clock);
      @(negedge i_clock);
      i_reset = 1'b0;
      @(negedge i_clock);
      compare(o_wr_valid, 1'b0, "wr_valid after reset");
      compare(o_rr_valid, 1'b0, "rr_valid after reset");
      compare(o_interrupt, 2'b00, "interrupts after reset");
      compare(o_status, 32'd1, "status after reset");
      compare(o_fifo_ready, 1'b1, "fifo ready after reset");

      for (int r = 0; r < NROWS; r++)
      begin
         base_bursts = bursts;
         base_irq0   = irq0_count;
         base_irq1   = irq1_count;
         base_rr     = rr_count;
         expect_addr = {rows[r].start_word, 3'b000};
         bp_pattern  = rows[r].ready_pattern;
         table_addr  = 64'h400 + 64'(r) * 64'h40;
         idx         = int'((table_addr >> 3) % 64);
         host_mem[idx]            = (64'(rows[r].desc_length) << 3) | 64'd1;
         host_mem[(idx + 1) % 64] = (64'(rows[r].start_word) << 3) | 64'd2;

         cur_match = rows[r].match_value;
         send_rx((64'(rows[r].match_value) << 3) | 64'd3, 1'b0);
         send_rx(table_addr | 64'd4, 1'b0);
         serve_read(table_addr);
         compare(rr_count, base_rr + 1, "read requests per table write");

         // less than a burst in the FIFO must not start a burst.
         push_words(8);
         repeat (12) @(negedge i_clock);
         compare(bursts, base_bursts, "bursts while starved");
         push_words(rows[r].push_words - 8);

         if (rows[r].abort)
         begin
            t = 0;
            while (!o_wr_valid)
            begin
               @(negedge i_clock);
               t++;
               if (t > LIMIT)
                  timeout_fail("burst request");
            end
            repeat (10) @(negedge i_clock);
            compare(bursts, base_bursts, "bursts under back-pressure");
            bp_pattern = 8'hff;
            t = 0;
            while (bursts == base_bursts)
            begin
               @(negedge i_clock);
               t++;
               if (t > LIMIT)
                  timeout_fail("burst acceptance before abort");
            end
            send_rx(64'd5, 1'b0);  // abort mid-burst.
            repeat (80) @(negedge i_clock);
            compare(bursts, base_bursts + 1, "bursts after abort");
            compare(words_seen % 16, 0, "words sent after abort");
            expect_words += 16;
         end
         else
         begin
            t = 0;
            while (bursts < base_bursts + rows[r].desc_length / 16)
            begin
               @(negedge i_clock);
               t++;
               if (t > LIMIT)
                  timeout_fail("burst count");
            end
            repeat (30) @(negedge i_clock);
            compare(bursts, base_bursts + rows[r].desc_length / 16, "bursts per descriptor");
            expect_words += rows[r].desc_length;
         end

         compare(words_seen, expect_words, "total words sent");
         compare(o_status[31:3], expect_words, "status word count");
         compare(o_status[0], 1'b1, "status fetcher idle");
         compare(o_rr_valid, 1'b0, "read request after completion");
         compare(irq0_count, base_irq0 + 1, "match interrupt pulses");
         compare(irq1_count, base_irq1 + 1, "idle interrupt pulses");
      end

      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== tb.f ====
rtl/dma_cmd_pkg.sv
rtl/pcie_tx_pkg.sv
rtl/async_fwft_fifo.sv
rtl/descriptor_fetch.sv
rtl/tpc_dma_channel.sv
rtl/tpc_dma_top.sv
testbench/tpc_dma_props.sv
testbench/tb_tpc_dma.sv

// ==== Bender.yml ====
package:
  name: tpc_dma

sources:
  - rtl/dma_cmd_pkg.sv
  - rtl/pcie_tx_pkg.sv
  - rtl/async_fwft_fifo.sv
  - rtl/descriptor_fetch.sv
  - rtl/tpc_dma_channel.sv
  - rtl/tpc_dma_top.sv
  - target: test
    files:
      - testbench/tpc_dma_props.sv
      - testbench/tb_tpc_dma.sv
